/* wbuf_defs.svh */
/*
 * Sizes for the write buffer. WBUF_NENTRIES must be a power of two,
 * and a line holds 2**(WBUF_LINE_OFF - WBUF_WORD_OFF) words
 */
`ifndef WBUF_DEFS_SVH
`define WBUF_DEFS_SVH

// Byte address width
`define WBUF_ADDR_W 32

// One buffered word per entry
`define WBUF_DATA_W 64

// Entry count, also the depth of the send FIFO
`define WBUF_NENTRIES 4

// Age counter and threshold width
`define WBUF_CNT_W 4

// Byte offset bits within a word
`define WBUF_WORD_OFF 3

// Byte offset bits within a cache line
`define WBUF_LINE_OFF 5

`endif

/* wbuf_pkg.sv */
/*
 * Shared types of the write buffer, sized by the macros in wbuf_defs.svh
 */
`include "wbuf_defs.svh"

package wbuf_pkg;

    // Life cycle of one buffer entry
    typedef enum logic [1:0] {
        WBUF_FREE = 2'b00,
        WBUF_OPEN = 2'b01,
        WBUF_PEND = 2'b10,
        WBUF_SENT = 2'b11
    } wbuf_state_e;

    // Word address, byte offset removed
    typedef logic [`WBUF_ADDR_W-`WBUF_WORD_OFF-1:0] wbuf_tag_t;

    // Entry index, doubles as the memory transaction id
    typedef logic [$clog2(`WBUF_NENTRIES)-1:0] wbuf_idx_t;

    typedef logic [`WBUF_DATA_W-1:0] wbuf_data_t;

    // One enable per data byte
    typedef logic [`WBUF_DATA_W/8-1:0] wbuf_be_t;

    // Age counter and timeout threshold
    typedef logic [`WBUF_CNT_W-1:0] wbuf_cnt_t;

endpackage

/* wbuf_if.sv */
/*
 * Internal links of the write buffer. Commands on wbuf_wr_if are taken
 * on the edge they are valid, with no handshake
 */
`timescale 1ns/1ps
`include "wbuf_defs.svh"

interface wbuf_wr_if;
    logic                                          wr_valid;
    logic                                          wr_alloc;
    wbuf_pkg::wbuf_idx_t                           wr_idx;
    wbuf_pkg::wbuf_tag_t                           wr_tag;
    wbuf_pkg::wbuf_data_t                          wr_data;
    wbuf_pkg::wbuf_be_t                            wr_be;
    logic                [`WBUF_NENTRIES-1:0]      flush_vec;
    wbuf_pkg::wbuf_state_e [`WBUF_NENTRIES-1:0]    state_vec;
    wbuf_pkg::wbuf_tag_t   [`WBUF_NENTRIES-1:0]    tag_vec;

    modport ctrl (
        output wr_valid, wr_alloc, wr_idx, wr_tag, wr_data, wr_be, flush_vec,
        input  state_vec, tag_vec
    );

    modport dir (
        input  wr_valid, wr_alloc, wr_idx, wr_tag, wr_data, wr_be, flush_vec,
        output state_vec, tag_vec
    );
endinterface

interface wbuf_send_if;
    logic [`WBUF_NENTRIES-1:0] pend_vec;
    logic                      take_valid;
    wbuf_pkg::wbuf_idx_t       take_idx;
    wbuf_pkg::wbuf_idx_t       rd_idx;
    wbuf_pkg::wbuf_tag_t       rd_tag;
    wbuf_pkg::wbuf_data_t      rd_data;
    wbuf_pkg::wbuf_be_t        rd_be;
    logic                      ack_valid;
    wbuf_pkg::wbuf_idx_t       ack_idx;

    modport dir (
        output pend_vec, rd_tag, rd_data, rd_be, ack_valid, ack_idx,
        input  take_valid, take_idx, rd_idx
    );

    modport send (
        input  pend_vec, rd_tag, rd_data, rd_be,
        output take_valid, take_idx, rd_idx
    );
endinterface

/* wbuf_write_ctrl.sv */
/*
 * Write admission. A tag that matches a SENT entry stalls until the
 * acknowledge; allocation always takes the lowest free entry
 */
`timescale 1ns/1ps
`include "wbuf_defs.svh"

module wbuf_write_ctrl (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 write_valid_i,
    output logic                 write_ready_o,
    input  logic [`WBUF_ADDR_W-1:0] write_addr_i,
    input  wbuf_pkg::wbuf_data_t write_data_i,
    input  wbuf_pkg::wbuf_be_t   write_be_i,
    input  logic [`WBUF_ADDR_W-1:0] read_addr_i,
    input  logic                 read_flush_i,
    output logic                 read_hit_o,
    wbuf_wr_if.ctrl              wr
);

    wbuf_pkg::wbuf_tag_t       write_tag;
    logic [`WBUF_NENTRIES-1:0] used_vec;
    logic [`WBUF_NENTRIES-1:0] tag_match;
    logic [`WBUF_NENTRIES-1:0] line_match;
    logic                      hit_merge;
    logic                      hit_sent;
    logic                      free_any;
    wbuf_pkg::wbuf_idx_t       hit_idx;
    wbuf_pkg::wbuf_idx_t       free_idx;

    assign write_tag = write_addr_i[`WBUF_ADDR_W-1:`WBUF_WORD_OFF];

    always_comb begin
        hit_merge = 1'b0;
        hit_sent  = 1'b0;
        free_any  = 1'b0;
        hit_idx   = '0;
        free_idx  = '0;
        for (int i = `WBUF_NENTRIES - 1; i >= 0; i--) begin
            used_vec[i]   = (wr.state_vec[i] != wbuf_pkg::WBUF_FREE);
            tag_match[i]  = used_vec[i] && (wr.tag_vec[i] == write_tag);
            // Compare the line part of the stored word tag
            line_match[i] = used_vec[i] &&
                (wr.tag_vec[i][`WBUF_ADDR_W-`WBUF_WORD_OFF-1:`WBUF_LINE_OFF-`WBUF_WORD_OFF]
                 == read_addr_i[`WBUF_ADDR_W-1:`WBUF_LINE_OFF]);
            if (tag_match[i]) begin
                if (wr.state_vec[i] == wbuf_pkg::WBUF_SENT) begin
                    hit_sent = 1'b1;
                end else begin
                    hit_merge = 1'b1;
                    hit_idx   = wbuf_pkg::wbuf_idx_t'(i);
                end
            end
            // Downward scan, so the lowest free index wins
            if (!used_vec[i]) begin
                free_any = 1'b1;
                free_idx = wbuf_pkg::wbuf_idx_t'(i);
            end
        end
    end

    assign write_ready_o = hit_merge || (!hit_sent && free_any);
    assign read_hit_o    = |line_match;

    // Command to the directory
    assign wr.wr_valid = write_valid_i && write_ready_o;
    assign wr.wr_alloc = !hit_merge;
    assign wr.wr_idx   = hit_merge ? hit_idx : free_idx;
    assign wr.wr_tag   = write_tag;
    assign wr.wr_data  = write_data_i;
    assign wr.wr_be    = write_be_i;

    always_comb begin
        for (int i = 0; i < `WBUF_NENTRIES; i++) begin
            wr.flush_vec[i] = read_flush_i && line_match[i] &&
                              (wr.state_vec[i] == wbuf_pkg::WBUF_OPEN);
        end
    end

    // Merging and stalling keep every used tag unique
    unique_tag_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $countones(tag_match) <= 1)
        else $error("write tag found in more than one entry");

endmodule

/* wbuf_dir.sv */
/*
 * Entry directory. OPEN entries age by one per cycle and turn PEND after
 * cfg_threshold_i cycles; merges never restart the age counter
 */
`timescale 1ns/1ps
`include "wbuf_defs.svh"

module wbuf_dir (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_all_i,
    input  wbuf_pkg::wbuf_cnt_t  cfg_threshold_i,
    input  logic                 mem_resp_valid_i,
    input  wbuf_pkg::wbuf_idx_t  mem_resp_id_i,
    output logic                 empty_o,
    output logic                 full_o,
    wbuf_wr_if.dir               wr,
    wbuf_send_if.dir             snd
);

    wbuf_pkg::wbuf_state_e [`WBUF_NENTRIES-1:0] state_q, state_d;
    wbuf_pkg::wbuf_cnt_t   [`WBUF_NENTRIES-1:0] cnt_q, cnt_d;
    wbuf_pkg::wbuf_tag_t   [`WBUF_NENTRIES-1:0] tag_q, tag_d;
    wbuf_pkg::wbuf_data_t  [`WBUF_NENTRIES-1:0] data_q;
    wbuf_pkg::wbuf_be_t    [`WBUF_NENTRIES-1:0] be_q;

    wbuf_pkg::wbuf_cnt_t thr_last;
    logic                direct_pend;

    // Last counter value before timeout
    assign thr_last    = cfg_threshold_i - 1'b1;
    assign direct_pend = flush_all_i || (cfg_threshold_i == '0);

    assign snd.ack_valid = mem_resp_valid_i;
    assign snd.ack_idx   = mem_resp_id_i;

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        tag_d   = tag_q;
        for (int i = 0; i < `WBUF_NENTRIES; i++) begin
            case (state_q[i])
                wbuf_pkg::WBUF_FREE: begin
                    if (wr.wr_valid && wr.wr_alloc && (wr.wr_idx == i)) begin
                        state_d[i] = direct_pend ? wbuf_pkg::WBUF_PEND : wbuf_pkg::WBUF_OPEN;
                        cnt_d[i]   = '0;
                        tag_d[i]   = wr.wr_tag;
                    end
                end
                wbuf_pkg::WBUF_OPEN: begin
                    cnt_d[i] = cnt_q[i] + 1'b1;
                    if (direct_pend || wr.flush_vec[i] || (cnt_q[i] == thr_last)) begin
                        state_d[i] = wbuf_pkg::WBUF_PEND;
                    end
                end
                wbuf_pkg::WBUF_PEND: begin
                    if (snd.take_valid && (snd.take_idx == i)) begin
                        state_d[i] = wbuf_pkg::WBUF_SENT;
                    end
                end
                default: begin
                    if (snd.ack_valid && (snd.ack_idx == i)) begin
                        state_d[i] = wbuf_pkg::WBUF_FREE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= {`WBUF_NENTRIES{wbuf_pkg::WBUF_FREE}};
            cnt_q   <= '0;
            tag_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
            tag_q   <= tag_d;
        end
    end

    // Byte merge; a fresh allocation overwrites the whole word
    always_ff @(posedge clk_i) begin
        if (wr.wr_valid) begin
            for (int b = 0; b < `WBUF_DATA_W / 8; b++) begin
                if (wr.wr_alloc || wr.wr_be[b]) begin
                    data_q[wr.wr_idx][8*b +: 8] <= wr.wr_data[8*b +: 8];
                end
            end
            be_q[wr.wr_idx] <= wr.wr_alloc ? wr.wr_be : (be_q[wr.wr_idx] | wr.wr_be);
        end
    end

    always_comb begin
        empty_o = 1'b1;
        full_o  = 1'b1;
        for (int i = 0; i < `WBUF_NENTRIES; i++) begin
            wr.state_vec[i] = state_q[i];
            wr.tag_vec[i]   = tag_q[i];
            snd.pend_vec[i] = (state_q[i] == wbuf_pkg::WBUF_PEND);
            if (state_q[i] == wbuf_pkg::WBUF_FREE) begin
                full_o = 1'b0;
            end else begin
                empty_o = 1'b0;
            end
        end
    end

    // Head of the send FIFO reads the entry it names
    assign snd.rd_tag  = tag_q[snd.rd_idx];
    assign snd.rd_data = data_q[snd.rd_idx];
    assign snd.rd_be   = be_q[snd.rd_idx];

    ack_sent_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        snd.ack_valid |-> (state_q[snd.ack_idx] == wbuf_pkg::WBUF_SENT))
        else $error("acknowledge names an entry that is not SENT");

    take_pend_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        snd.take_valid |-> (state_q[snd.take_idx] == wbuf_pkg::WBUF_PEND))
        else $error("send side took an entry that is not PEND");

endmodule

/* wbuf_send.sv */
/*
 * Send side. Round-robin pick of PEND entries into an index FIFO of
 * WBUF_NENTRIES slots; the request shows one cycle after the take at the earliest
 */
`timescale 1ns/1ps
`include "wbuf_defs.svh"

module wbuf_send (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     mem_req_ready_i,
    output logic                     mem_req_valid_o,
    output logic [`WBUF_ADDR_W-1:0]  mem_req_addr_o,
    output wbuf_pkg::wbuf_data_t     mem_req_data_o,
    output wbuf_pkg::wbuf_be_t       mem_req_be_o,
    output wbuf_pkg::wbuf_idx_t      mem_req_id_o,
    wbuf_send_if.send                snd
);

    wbuf_pkg::wbuf_idx_t                      rr_q;
    wbuf_pkg::wbuf_idx_t                      pick;
    wbuf_pkg::wbuf_idx_t [`WBUF_NENTRIES-1:0] fifo_q;
    wbuf_pkg::wbuf_idx_t                      wptr_q;
    wbuf_pkg::wbuf_idx_t                      rptr_q;
    logic [$clog2(`WBUF_NENTRIES):0]          count_q;
    logic                                     fifo_full;
    logic                                     push;
    logic                                     pop;

    // Search starts at the entry after the last one taken
    always_comb begin
        wbuf_pkg::wbuf_idx_t cand;
        logic                found;
        pick  = rr_q;
        found = 1'b0;
        for (int k = 0; k < `WBUF_NENTRIES; k++) begin
            cand = rr_q + wbuf_pkg::wbuf_idx_t'(k);
            if (!found && snd.pend_vec[cand]) begin
                pick  = cand;
                found = 1'b1;
            end
        end
    end

    assign fifo_full      = (count_q == `WBUF_NENTRIES);
    assign push           = (|snd.pend_vec) && !fifo_full;
    assign pop            = mem_req_valid_o && mem_req_ready_i;
    assign snd.take_valid = push;
    assign snd.take_idx   = pick;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rr_q    <= '0;
            wptr_q  <= '0;
            rptr_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                rr_q   <= pick + 1'b1;
                wptr_q <= wptr_q + 1'b1;
            end
            if (pop) begin
                rptr_q <= rptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_q[wptr_q] <= pick;
        end
    end

    // Payload comes from the entry named at the head
    assign snd.rd_idx      = fifo_q[rptr_q];
    assign mem_req_valid_o = (count_q != '0);
    assign mem_req_addr_o  = {snd.rd_tag, {`WBUF_WORD_OFF{1'b0}}};
    assign mem_req_data_o  = snd.rd_data;
    assign mem_req_be_o    = snd.rd_be;
    assign mem_req_id_o    = snd.rd_idx;

    // Queued indices are all SENT so a full FIFO leaves no PEND entry
    no_overflow_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (|snd.pend_vec) |-> !fifo_full)
        else $error("PEND entry waits while the send FIFO is full");

endmodule

/* wbuf_top.sv */
/*
 * Coalescing write buffer between a cache and memory. Acknowledges are
 * always accepted and must name a SENT entry by its request id
 */
`timescale 1ns/1ps
`include "wbuf_defs.svh"

module wbuf_top (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_all_i,
    input  wbuf_pkg::wbuf_cnt_t      cfg_threshold_i,
    output logic                     empty_o,
    output logic                     full_o,
    // Write channel from the cache
    input  logic                     write_valid_i,
    output logic                     write_ready_o,
    input  logic [`WBUF_ADDR_W-1:0]  write_addr_i,
    input  wbuf_pkg::wbuf_data_t     write_data_i,
    input  wbuf_pkg::wbuf_be_t       write_be_i,
    // Read lookup
    input  logic [`WBUF_ADDR_W-1:0]  read_addr_i,
    input  logic                     read_flush_i,
    output logic                     read_hit_o,
    // Memory request and acknowledge
    output logic                     mem_req_valid_o,
    input  logic                     mem_req_ready_i,
    output logic [`WBUF_ADDR_W-1:0]  mem_req_addr_o,
    output wbuf_pkg::wbuf_data_t     mem_req_data_o,
    output wbuf_pkg::wbuf_be_t       mem_req_be_o,
    output wbuf_pkg::wbuf_idx_t      mem_req_id_o,
    input  logic                     mem_resp_valid_i,
    input  wbuf_pkg::wbuf_idx_t      mem_resp_id_i
);

    wbuf_wr_if   wr_if ();
    wbuf_send_if snd_if ();

    wbuf_write_ctrl wbuf_write_ctrl_i (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .write_valid_i (write_valid_i),
        .write_ready_o (write_ready_o),
        .write_addr_i  (write_addr_i),
        .write_data_i  (write_data_i),
        .write_be_i    (write_be_i),
        .read_addr_i   (read_addr_i),
        .read_flush_i  (read_flush_i),
        .read_hit_o    (read_hit_o),
        .wr            (wr_if.ctrl)
    );

    wbuf_dir wbuf_dir_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_all_i      (flush_all_i),
        .cfg_threshold_i  (cfg_threshold_i),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_id_i    (mem_resp_id_i),
        .empty_o          (empty_o),
        .full_o           (full_o),
        .wr               (wr_if.dir),
        .snd              (snd_if.dir)
    );

    wbuf_send wbuf_send_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_req_data_o  (mem_req_data_o),
        .mem_req_be_o    (mem_req_be_o),
        .mem_req_id_o    (mem_req_id_o),
        .snd             (snd_if.send)
    );

endmodule

/* tb_clk_gen.sv */
/*
 * Clock with a 20 ns period. Reset is held low for the first 5 cycles
 * and released on a falling edge
 */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o  = 1'b1;
        rst_no = 1'b0;
        repeat (5) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

    always #10 clk_o = ~clk_o;

endmodule

/* tb_wbuf.sv */
/*
 * Testbench for wbuf_top. Acknowledges return in request order after a
 * random delay, and request data is compared on enabled bytes only
 */
`timescale 1ns/1ps
`include "wbuf_defs.svh"

module tb_wbuf;

    localparam int TIMEOUT = 200;

    logic clk_i;
    logic rst_ni;
    logic flush_all_i;
    wbuf_pkg::wbuf_cnt_t cfg_threshold_i;
    logic empty_o;
    logic full_o;
    logic write_valid_i;
    logic write_ready_o;
    logic [`WBUF_ADDR_W-1:0] write_addr_i;
    wbuf_pkg::wbuf_data_t write_data_i;
    wbuf_pkg::wbuf_be_t write_be_i;
    logic [`WBUF_ADDR_W-1:0] read_addr_i;
    logic read_flush_i;
    logic read_hit_o;
    logic mem_req_valid_o;
    logic mem_req_ready_i;
    logic [`WBUF_ADDR_W-1:0] mem_req_addr_o;
    wbuf_pkg::wbuf_data_t mem_req_data_o;
    wbuf_pkg::wbuf_be_t mem_req_be_o;
    wbuf_pkg::wbuf_idx_t mem_req_id_o;
    logic mem_resp_valid_i;
    wbuf_pkg::wbuf_idx_t mem_resp_id_i;

    // Reference model with one slot per buffered word
    logic [`WBUF_ADDR_W-1:0] exp_addr[$];
    wbuf_pkg::wbuf_data_t exp_data[$];
    wbuf_pkg::wbuf_be_t exp_be[$];
    wbuf_pkg::wbuf_idx_t exp_idx[$];
    logic [`WBUF_NENTRIES-1:0] busy = '0;
    wbuf_pkg::wbuf_idx_t ack_ids[$];
    int ack_due[$];
    int acks_open = 0;
    int cycle = 0;
    int req_count = 0;
    int ready_mode = 0;  // 0 random, 1 held low, 2 held high
    logic ack_hold = 1'b0;
    logic [31:0] stim_rng = 32'h2b675066;
    logic [31:0] mem_rng = 32'h2b675066 ^ 32'h9e3779b9;
    string test_name = "reset";

    tb_clk_gen tb_clk_gen_i (.clk_o(clk_i), .rst_no(rst_ni));

    wbuf_top wbuf_top_i (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] stim_rand();
        stim_rng = xorshift32(stim_rng);
        return stim_rng;
    endfunction

    // Enabled bytes take the new value
    function automatic wbuf_pkg::wbuf_data_t merge_bytes(input wbuf_pkg::wbuf_data_t old_d,
            input wbuf_pkg::wbuf_data_t new_d, input wbuf_pkg::wbuf_be_t new_be);
        wbuf_pkg::wbuf_data_t res;
        res = old_d;
        for (int b = 0; b < `WBUF_DATA_W / 8; b++) begin
            if (new_be[b]) begin
                res[8*b +: 8] = new_d[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic int find_word(input logic [`WBUF_ADDR_W-1:0] addr);
        for (int i = 0; i < exp_addr.size(); i++) begin
            if (exp_addr[i] == addr) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_req(input logic [`WBUF_ADDR_W-1:0] addr,
            input wbuf_pkg::wbuf_data_t exp_d, input wbuf_pkg::wbuf_data_t act_d,
            input wbuf_pkg::wbuf_be_t exp_b, input wbuf_pkg::wbuf_be_t act_b,
            input wbuf_pkg::wbuf_idx_t exp_i, input wbuf_pkg::wbuf_idx_t act_i);
        wbuf_pkg::wbuf_data_t mask;
        mask = merge_bytes('0, '1, exp_b);
        if (act_i !== exp_i) begin
            report_failure($sformatf("ERR %s: id at %h expected %0d actual %0d",
                test_name, addr, exp_i, act_i));
        end
        if (act_b !== exp_b) begin
            report_failure($sformatf("ERR %s: be at %h expected %h actual %h",
                test_name, addr, exp_b, act_b));
        end
        if ((act_d & mask) !== (exp_d & mask)) begin
            report_failure($sformatf("ERR %s: data at %h expected %h actual %h",
                test_name, addr, exp_d & mask, act_d & mask));
        end
    endtask

    task automatic check_flag(input string what, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            report_failure($sformatf("ERR %s: %s expected %b actual %b",
                test_name, what, exp_v, act_v));
        end
    endtask

    // Request checker sampled on the transfer edge
    always @(posedge clk_i) begin : req_check
        int k;
        cycle++;
        if (rst_ni && mem_resp_valid_i) begin
            acks_open--;
        end
        if (rst_ni && mem_req_valid_o && mem_req_ready_i) begin
            k = find_word(mem_req_addr_o);
            if (k < 0) begin
                report_failure($sformatf("%s: request to %h with no buffered write",
                    test_name, mem_req_addr_o));
            end
            check_req(mem_req_addr_o, exp_data[k], mem_req_data_o, exp_be[k], mem_req_be_o,
                exp_idx[k], mem_req_id_o);
            exp_addr.delete(k);
            exp_data.delete(k);
            exp_be.delete(k);
            exp_idx.delete(k);
            mem_rng = xorshift32(mem_rng);
            ack_ids.push_back(mem_req_id_o);
            ack_due.push_back(cycle + int'(mem_rng % 6));
            acks_open++;
            req_count++;
        end
    end

    // Memory model for ready and acknowledges
    always @(negedge clk_i) begin
        // Entry acknowledged on the last edge is free again
        if (mem_resp_valid_i) begin
            busy[mem_resp_id_i] = 1'b0;
        end
        mem_rng = xorshift32(mem_rng);
        case (ready_mode)
            1:       mem_req_ready_i = 1'b0;
            2:       mem_req_ready_i = 1'b1;
            default: mem_req_ready_i = (mem_rng[1:0] != 2'b00);
        endcase
        mem_resp_valid_i = 1'b0;
        if (!ack_hold && ack_ids.size() > 0 && cycle >= ack_due[0]) begin
            mem_resp_valid_i = 1'b1;
            mem_resp_id_i    = ack_ids.pop_front();
            void'(ack_due.pop_front());
        end
    end

    task automatic present_write(input logic [`WBUF_ADDR_W-1:0] addr,
            input wbuf_pkg::wbuf_data_t d, input wbuf_pkg::wbuf_be_t be);
        @(negedge clk_i);
        write_valid_i = 1'b1;
        write_addr_i  = addr;
        write_data_i  = d;
        write_be_i    = be;
    endtask

    task automatic wait_accept();
        logic [`WBUF_ADDR_W-1:0] key;
        int n;
        int k;
        int slot;
        n = 0;
        @(posedge clk_i);
        while (!write_ready_o) begin
            n++;
            if (n > TIMEOUT) begin
                report_failure($sformatf("%s: write to %h never accepted", test_name,
                    write_addr_i));
            end
            @(posedge clk_i);
        end
        key = {write_addr_i[`WBUF_ADDR_W-1:`WBUF_WORD_OFF], {`WBUF_WORD_OFF{1'b0}}};
        k = find_word(key);
        if (k >= 0) begin
            exp_data[k] = merge_bytes(exp_data[k], write_data_i, write_be_i);
            exp_be[k]   = exp_be[k] | write_be_i;
        end else begin
            // New words go to the lowest free entry
            slot = -1;
            for (int i = `WBUF_NENTRIES - 1; i >= 0; i--) begin
                if (!busy[i]) begin
                    slot = i;
                end
            end
            if (slot < 0) begin
                report_failure($sformatf("%s: write to %h accepted with every entry in use",
                    test_name, write_addr_i));
            end
            busy[slot] = 1'b1;
            exp_addr.push_back(key);
            exp_data.push_back(write_data_i);
            exp_be.push_back(write_be_i);
            exp_idx.push_back(wbuf_pkg::wbuf_idx_t'(slot));
        end
    endtask

    task automatic drive_write(input logic [`WBUF_ADDR_W-1:0] addr);
        present_write(addr, {stim_rand(), stim_rand()}, wbuf_pkg::wbuf_be_t'(stim_rand()));
        wait_accept();
    endtask

    task automatic end_writes();
        @(negedge clk_i);
        write_valid_i = 1'b0;
    endtask

    task automatic wait_count(input int target, input int limit);
        int n;
        n = 0;
        while (req_count < target) begin
            @(negedge clk_i);
            n++;
            if (n > limit) begin
                report_failure($sformatf("%s: only %0d of %0d requests arrived in time",
                    test_name, req_count, target));
            end
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
            if (n > TIMEOUT) begin
                report_failure($sformatf("%s: buffer did not drain", test_name));
            end
        end while (exp_addr.size() != 0 || acks_open != 0);
        check_flag("empty_o after drain", 1'b1, empty_o);
    endtask

    initial begin : scenarios
        int base;
        int nw;
        flush_all_i     = 1'b0;
        cfg_threshold_i = 4'd4;
        write_valid_i   = 1'b0;
        write_addr_i    = '0;
        write_data_i    = '0;
        write_be_i      = '0;
        read_addr_i     = '0;
        read_flush_i    = 1'b0;
        mem_req_ready_i = 1'b0;
        mem_resp_valid_i = 1'b0;
        mem_resp_id_i   = '0;
        base = 0;
        while (rst_ni !== 1'b1) begin
            @(negedge clk_i);
            base++;
            if (base > TIMEOUT) begin
                report_failure("reset was never released");
            end
        end
        check_flag("empty_o", 1'b1, empty_o);
        check_flag("full_o", 1'b0, full_o);
        check_flag("write_ready_o", 1'b1, write_ready_o);
        check_flag("mem_req_valid_o", 1'b0, mem_req_valid_o);

        test_name = "single";
        drive_write(32'h0000_1234);
        end_writes();
        wait_drained();

        test_name = "coalesce";
        cfg_threshold_i = 4'd15;
        nw = 2 + int'(stim_rand() % 3);
        for (int i = 0; i < nw; i++) begin
            drive_write(32'h0000_2008 | (stim_rand() & 32'h7));
        end
        end_writes();
        wait_drained();

        test_name = "immediate";
        cfg_threshold_i = 4'd0;
        for (int i = 0; i < 4; i++) begin
            drive_write(32'h0000_3000 + 8 * i);
        end
        end_writes();
        cfg_threshold_i = 4'd15;
        flush_all_i = 1'b1;
        for (int i = 0; i < 3; i++) begin
            drive_write(32'h0000_3100 + 8 * i);
        end
        end_writes();
        wait_drained();
        flush_all_i = 1'b0;

        test_name = "read";
        ready_mode = 2;
        base = req_count;
        drive_write(32'h0000_4010);
        end_writes();
        read_addr_i = 32'h0000_401c;
        @(posedge clk_i);
        check_flag("read_hit_o same line", 1'b1, read_hit_o);
        @(negedge clk_i);
        read_addr_i = 32'h0000_4020;
        @(posedge clk_i);
        check_flag("read_hit_o other line", 1'b0, read_hit_o);
        @(negedge clk_i);
        read_addr_i  = 32'h0000_4008;
        read_flush_i = 1'b1;
        @(negedge clk_i);
        read_flush_i = 1'b0;
        // Well before the 15 cycle timeout
        wait_count(base + 1, 8);
        wait_drained();

        test_name = "full";
        ready_mode = 1;
        cfg_threshold_i = 4'd0;
        base = req_count;
        for (int i = 0; i < 4; i++) begin
            drive_write(32'h0000_5000 + 8 * i);
        end
        end_writes();
        check_flag("full_o", 1'b1, full_o);
        present_write(32'h0000_5100, {stim_rand(), stim_rand()}, 8'hff);
        @(posedge clk_i);
        check_flag("write_ready_o when full", 1'b0, write_ready_o);
        end_writes();
        ready_mode = 0;
        wait_count(base + 4, TIMEOUT);
        wait_drained();

        test_name = "write after sent";
        ready_mode = 2;
        ack_hold = 1'b1;
        base = req_count;
        drive_write(32'h0000_6000);
        end_writes();
        wait_count(base + 1, TIMEOUT);
        present_write(32'h0000_6000, {stim_rand(), stim_rand()},
            wbuf_pkg::wbuf_be_t'(stim_rand() | 32'h1));
        repeat (3) begin
            @(posedge clk_i);
            check_flag("write_ready_o on SENT tag", 1'b0, write_ready_o);
        end
        ack_hold = 1'b0;
        wait_accept();
        end_writes();
        wait_drained();

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
wbuf_pkg.sv
wbuf_if.sv
wbuf_write_ctrl.sv
wbuf_dir.sv
wbuf_send.sv
wbuf_top.sv
tb_clk_gen.sv
tb_wbuf.sv
